//--- hw/decode_defines.svh
// Decode stage constants
// Widths, PC reset address, RV32I major opcodes and trap causes
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define XLEN            32              // Data and PC width
`define REG_ADDR_W      5               // Register address width
`define PC_RESET_ADDR   32'h1000_0000   // PC after reset

// Major opcodes in instruction bits 6:0
// ----------------------------------------
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011
`define OPC_OP_IMM      7'b0010011
`define OPC_OP          7'b0110011
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_SYSTEM      7'b1110011

// Trap causes
// ----------------------------------------
`define TRAP_IACCESS    7'd1            // Instruction fetch error
`define TRAP_IOPCODE    7'd2            // Invalid opcode

`endif

//--- hw/decode_pkg.sv
// Decode package
// One 32-bit instruction word with its R, I, S/B and U/J field views
`default_nettype none

package decode_pkg;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;                            // Register-register view
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;                            // Immediate view
        struct packed {
            logic [6:0] imm_hi;         // Bits 31:25
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;         // Bits 11:7
            logic [6:0] opcode;
        } sb;                           // Store and branch view
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uj;                           // Upper and jump view
    } instr_word_u;

endpackage

`default_nettype wire

//--- hw/pc_tracker.sv
// Program counter tracker
// Holds the PC of the instruction in decode, advancing by 4 on each
// consumed instruction and loading the target on a control flow change
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module pc_tracker (
    input  wire                 g_clk,
    input  wire                 g_resetn,
    input  wire                 advance_i,      // Instruction eaten
    input  wire                 redirect_i,     // Acknowledged control flow change
    input  wire  [`XLEN-1:0]    target_i,
    output logic [`XLEN-1:0]    pc_o,
    output logic [`XLEN-1:0]    npc_o
);

    logic [`XLEN-1:0] pc_q;

    assign pc_o  = pc_q;
    assign npc_o = pc_q + `XLEN'd4;     // Only 4-byte instructions

    // PC update
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= `PC_RESET_ADDR;
        end else if (redirect_i) begin
            pc_q <= target_i;           // Redirect wins over advance
        end else if (advance_i) begin
            pc_q <= npc_o;
        end
    end

endmodule

`default_nettype wire

//--- hw/imm_gen.sv
// Immediate generator
// Picks the I, S, B, U or J immediate from the major opcode and
// sign-extends it to the full data width
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module imm_gen (
    input  wire decode_pkg::instr_word_u    instr_i,
    output logic [`XLEN-1:0]                imm_o
);

    logic [`XLEN-1:0] imm_i_fmt;
    logic [`XLEN-1:0] imm_s_fmt;
    logic [`XLEN-1:0] imm_b_fmt;
    logic [`XLEN-1:0] imm_u_fmt;
    logic [`XLEN-1:0] imm_j_fmt;

    // Format extraction
    // ----------------------------------------
    assign imm_i_fmt = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};

    assign imm_s_fmt = {{20{instr_i.sb.imm_hi[6]}}, instr_i.sb.imm_hi, instr_i.sb.imm_lo};

    assign imm_b_fmt = {{20{instr_i.sb.imm_hi[6]}},
                        instr_i.sb.imm_lo[0],           // imm[11]
                        instr_i.sb.imm_hi[5:0],         // imm[10:5]
                        instr_i.sb.imm_lo[4:1],         // imm[4:1]
                        1'b0};

    assign imm_u_fmt = {instr_i.uj.imm, 12'b0};

    assign imm_j_fmt = {{12{instr_i.uj.imm[19]}},
                        instr_i.uj.imm[7:0],            // imm[19:12]
                        instr_i.uj.imm[8],              // imm[11]
                        instr_i.uj.imm[18:9],           // imm[10:1]
                        1'b0};

    // Format select
    // ----------------------------------------
    always_comb begin
        case (instr_i.uj.opcode)
            `OPC_LOAD,
            `OPC_OP_IMM,
            `OPC_JALR:   imm_o = imm_i_fmt;
            `OPC_STORE:  imm_o = imm_s_fmt;
            `OPC_BRANCH: imm_o = imm_b_fmt;
            `OPC_LUI,
            `OPC_AUIPC:  imm_o = imm_u_fmt;
            `OPC_JAL:    imm_o = imm_j_fmt;
            default:     imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/op_decoder.sv
// RV32I instruction decoder
// Recognises legal encodings and produces register addresses, one-hot
// micro-op flags, writeback selects, operand controls and traps
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module op_decoder (
    input  wire decode_pkg::instr_word_u    instr_i,
    input  wire [1:0]                       ferr_i,     // Fetch error per halfword
    output logic [`REG_ADDR_W-1:0]          rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]          rs2_addr_o,
    output logic [`REG_ADDR_W-1:0]          rd_o,
    output logic alu_add_o, alu_sub_o, alu_and_o, alu_or_o, alu_xor_o,
    output logic alu_sll_o, alu_srl_o, alu_sra_o, alu_slt_o, alu_sltu_o,
    output logic cfu_beq_o, cfu_bne_o, cfu_blt_o, cfu_bge_o, cfu_bltu_o,
    output logic cfu_bgeu_o, cfu_jal_o, cfu_jalr_o, cfu_ecall_o, cfu_ebrk_o,
    output logic lsu_load_o, lsu_store_o, lsu_byte_o, lsu_half_o,
    output logic lsu_word_o, lsu_sext_o,
    output logic wb_alu_o, wb_lsu_o, wb_npc_o,
    output logic use_imm_o, use_shamt_imm_o, lhs_pc_o, lhs_zero_o,
    output logic                            trap_o,
    output logic [6:0]                      trap_cause_o
);

    logic [2:0] f3;
    logic       f7_zero, f7_alt;
    logic       is_load, is_store, is_branch, is_op_imm, is_op;
    logic       is_lui, is_auipc, is_jal, is_jalr, is_system;
    logic       op_ok, op_imm_ok, load_ok, store_ok, branch_ok, jalr_ok;
    logic       arith, sys_base, legal, iaccess, mem_ok, alu_any;

    assign f3      = instr_i.r.funct3;
    assign f7_zero = instr_i.r.funct7 == 7'b0000000;
    assign f7_alt  = instr_i.r.funct7 == 7'b0100000;    // SUB, SRA, SRAI

    // Major opcode
    // ----------------------------------------
    assign is_load   = instr_i.r.opcode == `OPC_LOAD;
    assign is_store  = instr_i.r.opcode == `OPC_STORE;
    assign is_branch = instr_i.r.opcode == `OPC_BRANCH;
    assign is_op_imm = instr_i.r.opcode == `OPC_OP_IMM;
    assign is_op     = instr_i.r.opcode == `OPC_OP;
    assign is_lui    = instr_i.r.opcode == `OPC_LUI;
    assign is_auipc  = instr_i.r.opcode == `OPC_AUIPC;
    assign is_jal    = instr_i.r.opcode == `OPC_JAL;
    assign is_jalr   = instr_i.r.opcode == `OPC_JALR;
    assign is_system = instr_i.r.opcode == `OPC_SYSTEM;

    // Legal funct3/funct7 per opcode group
    assign op_ok     = is_op && (f7_zero || (f7_alt && (f3 == 3'd0 || f3 == 3'd5)));
    assign op_imm_ok = is_op_imm && (f3 == 3'd1 ? f7_zero :
                                     f3 == 3'd5 ? (f7_zero || f7_alt) : 1'b1);
    assign load_ok   = is_load && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd2 ||
                                   f3 == 3'd4 || f3 == 3'd5);
    assign store_ok  = is_store && f3 < 3'd3;
    assign branch_ok = is_branch && f3 != 3'd2 && f3 != 3'd3;
    assign jalr_ok   = is_jalr && f3 == 3'd0;
    assign sys_base  = is_system && f7_zero && instr_i.r.rs1 == '0 &&
                       f3 == 3'd0 && instr_i.r.rd == '0;

    assign cfu_ecall_o = sys_base && instr_i.r.rs2 == 5'd0;
    assign cfu_ebrk_o  = sys_base && instr_i.r.rs2 == 5'd1;

    assign legal = op_ok || op_imm_ok || load_ok || store_ok || branch_ok ||
                   jalr_ok || is_jal || is_lui || is_auipc ||
                   cfu_ecall_o || cfu_ebrk_o;

    // Register addresses
    // ----------------------------------------
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;
    assign rd_o       = (is_store || is_branch) ? '0 : instr_i.r.rd;

    // ALU, OP and OP-IMM share the funct3 map
    // ----------------------------------------
    assign arith      = op_ok || op_imm_ok;
    assign alu_add_o  = (arith && f3 == 3'd0 && !(is_op && f7_alt)) ||
                        is_auipc || load_ok || store_ok;    // AUIPC, address calc
    assign alu_sub_o  = (op_ok && f3 == 3'd0 && f7_alt) || branch_ok;
    assign alu_sll_o  = arith && f3 == 3'd1;
    assign alu_slt_o  = arith && f3 == 3'd2;
    assign alu_sltu_o = arith && f3 == 3'd3;
    assign alu_xor_o  = arith && f3 == 3'd4;
    assign alu_srl_o  = arith && f3 == 3'd5 && f7_zero;
    assign alu_sra_o  = arith && f3 == 3'd5 && f7_alt;
    assign alu_or_o   = (arith && f3 == 3'd6) || is_lui;    // LUI is 0 | imm
    assign alu_and_o  = arith && f3 == 3'd7;

    assign use_imm_o       = op_imm_ok || is_lui || is_auipc || load_ok || store_ok;
    assign use_shamt_imm_o = op_imm_ok && f3[1:0] == 2'b01;
    assign lhs_pc_o        = is_auipc;
    assign lhs_zero_o      = is_lui;

    // Control flow
    assign cfu_beq_o  = branch_ok && f3 == 3'd0;
    assign cfu_bne_o  = branch_ok && f3 == 3'd1;
    assign cfu_blt_o  = branch_ok && f3 == 3'd4;
    assign cfu_bge_o  = branch_ok && f3 == 3'd5;
    assign cfu_bltu_o = branch_ok && f3 == 3'd6;
    assign cfu_bgeu_o = branch_ok && f3 == 3'd7;
    assign cfu_jal_o  = is_jal;
    assign cfu_jalr_o = jalr_ok;

    // Traps, fetch error over invalid opcode
    // ----------------------------------------
    assign iaccess      = |ferr_i;
    assign trap_o       = iaccess || !legal;
    assign trap_cause_o = iaccess ? `TRAP_IACCESS :
                          !legal  ? `TRAP_IOPCODE : 7'd0;

    // Load/store, quiet on a trap
    assign mem_ok      = (load_ok || store_ok) && !trap_o;
    assign lsu_load_o  = mem_ok && is_load;
    assign lsu_store_o = mem_ok && is_store;
    assign lsu_byte_o  = mem_ok && f3[1:0] == 2'd0;
    assign lsu_half_o  = mem_ok && f3[1:0] == 2'd1;
    assign lsu_word_o  = mem_ok && f3[1:0] == 2'd2;
    assign lsu_sext_o  = mem_ok && is_load && !f3[2];       // LB, LH, LW

    // Writeback select
    assign alu_any  = alu_add_o || alu_sub_o || alu_and_o || alu_or_o ||
                      alu_xor_o || alu_sll_o || alu_srl_o || alu_sra_o ||
                      alu_slt_o || alu_sltu_o;
    assign wb_npc_o = !trap_o && (cfu_jal_o || cfu_jalr_o);
    assign wb_lsu_o = lsu_load_o;
    assign wb_alu_o = !trap_o && alu_any && !branch_ok && !load_ok;

endmodule

`default_nettype wire

//--- hw/operand_mux.sv
// ALU operand mux
// Chooses the left and right ALU operands and the shift amount
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module operand_mux (
    input  wire  [`XLEN-1:0]    pc_i,
    input  wire  [`XLEN-1:0]    imm_i,
    input  wire  [`XLEN-1:0]    rs1_data_i,
    input  wire  [`XLEN-1:0]    rs2_data_i,
    input  wire                 use_imm_i,          // Immediate as right operand
    input  wire                 use_shamt_imm_i,    // SLLI, SRLI, SRAI
    input  wire                 lhs_pc_i,           // AUIPC
    input  wire                 lhs_zero_i,         // LUI
    input  wire  [4:0]          shamt_field_i,      // Instruction bits 24:20
    output logic [`XLEN-1:0]    alu_lhs_o,
    output logic [`XLEN-1:0]    alu_rhs_o,
    output logic [4:0]          alu_shamt_o
);

    // Left operand
    // ----------------------------------------
    assign alu_lhs_o = lhs_pc_i   ? pc_i :
                       lhs_zero_i ? '0   :
                                    rs1_data_i;

    // Right operand and shift amount
    // ----------------------------------------
    assign alu_rhs_o   = use_imm_i ? imm_i : rs2_data_i;

    assign alu_shamt_o = use_shamt_imm_i ? shamt_field_i : rs2_data_i[4:0];

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
// Decode and operand gather stage
// Takes one RV32I instruction from fetch, decodes it, gathers operands
// and hands it to execute while tracking the program counter
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module decode_stage (
    input  wire                     g_clk,
    input  wire                     g_resetn,
    input  wire                     s1_valid_i,         // Instruction present
    input  wire  [31:0]             s1_instr_i,
    input  wire  [1:0]              s1_ferr_i,
    output logic                    s1_eat_o,           // Instruction taken this edge
    input  wire                     cf_valid_i,
    input  wire                     cf_ack_i,
    input  wire  [`XLEN-1:0]        cf_target_i,
    output logic [`REG_ADDR_W-1:0]  s1_rs1_addr_o,
    input  wire  [`XLEN-1:0]        s1_rs1_data_i,      // Forwarded
    output logic [`REG_ADDR_W-1:0]  s1_rs2_addr_o,
    input  wire  [`XLEN-1:0]        s1_rs2_data_i,      // Forwarded
    input  wire                     s2_ready_i,
    output logic                    s2_valid_o,
    output logic [`XLEN-1:0]        s2_pc_o,
    output logic [`XLEN-1:0]        s2_npc_o,
    output logic [31:0]             s2_instr_o,
    output logic [`XLEN-1:0]        s2_imm_o,
    output logic [`REG_ADDR_W-1:0]  s2_rd_o,
    output logic [`XLEN-1:0]        s2_rs1_data_o,
    output logic [`XLEN-1:0]        s2_rs2_data_o,
    output logic [`XLEN-1:0]        s2_alu_lhs_o,
    output logic [`XLEN-1:0]        s2_alu_rhs_o,
    output logic [4:0]              s2_alu_shamt_o,
    output logic                    s2_trap_o,
    output logic [6:0]              s2_trap_cause_o,
    output logic s2_alu_add_o, s2_alu_sub_o, s2_alu_and_o, s2_alu_or_o, s2_alu_xor_o,
    output logic s2_alu_sll_o, s2_alu_srl_o, s2_alu_sra_o, s2_alu_slt_o, s2_alu_sltu_o,
    output logic s2_cfu_beq_o, s2_cfu_bne_o, s2_cfu_blt_o, s2_cfu_bge_o, s2_cfu_bltu_o,
    output logic s2_cfu_bgeu_o, s2_cfu_jal_o, s2_cfu_jalr_o, s2_cfu_ecall_o, s2_cfu_ebrk_o,
    output logic s2_lsu_load_o, s2_lsu_store_o, s2_lsu_byte_o, s2_lsu_half_o,
    output logic s2_lsu_word_o, s2_lsu_sext_o,
    output logic s2_wb_alu_o, s2_wb_lsu_o, s2_wb_npc_o
);

    decode_pkg::instr_word_u s1_word;
    logic cf_redirect;
    logic use_imm, use_shamt_imm, lhs_pc, lhs_zero;

    // Stage handoff
    // ----------------------------------------
    assign s1_eat_o      = s1_valid_i && s2_ready_i;
    assign s2_valid_o    = s1_valid_i;
    assign s2_instr_o    = s1_instr_i;
    assign s2_rs1_data_o = s1_rs1_data_i;
    assign s2_rs2_data_o = s1_rs2_data_i;
    assign s1_word       = decode_pkg::instr_word_u'(s1_instr_i);
    assign cf_redirect   = cf_valid_i && cf_ack_i;

    pc_tracker u_pc (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .advance_i(s1_eat_o), .redirect_i(cf_redirect), .target_i(cf_target_i),
        .pc_o(s2_pc_o), .npc_o(s2_npc_o)
    );

    imm_gen u_imm (
        .instr_i(s1_word), .imm_o(s2_imm_o)
    );

    op_decoder u_dec (
        .instr_i(s1_word), .ferr_i(s1_ferr_i),
        .rs1_addr_o(s1_rs1_addr_o), .rs2_addr_o(s1_rs2_addr_o), .rd_o(s2_rd_o),
        .alu_add_o(s2_alu_add_o), .alu_sub_o(s2_alu_sub_o), .alu_and_o(s2_alu_and_o),
        .alu_or_o(s2_alu_or_o), .alu_xor_o(s2_alu_xor_o), .alu_sll_o(s2_alu_sll_o),
        .alu_srl_o(s2_alu_srl_o), .alu_sra_o(s2_alu_sra_o), .alu_slt_o(s2_alu_slt_o),
        .alu_sltu_o(s2_alu_sltu_o),
        .cfu_beq_o(s2_cfu_beq_o), .cfu_bne_o(s2_cfu_bne_o), .cfu_blt_o(s2_cfu_blt_o),
        .cfu_bge_o(s2_cfu_bge_o), .cfu_bltu_o(s2_cfu_bltu_o), .cfu_bgeu_o(s2_cfu_bgeu_o),
        .cfu_jal_o(s2_cfu_jal_o), .cfu_jalr_o(s2_cfu_jalr_o),
        .cfu_ecall_o(s2_cfu_ecall_o), .cfu_ebrk_o(s2_cfu_ebrk_o),
        .lsu_load_o(s2_lsu_load_o), .lsu_store_o(s2_lsu_store_o),
        .lsu_byte_o(s2_lsu_byte_o), .lsu_half_o(s2_lsu_half_o),
        .lsu_word_o(s2_lsu_word_o), .lsu_sext_o(s2_lsu_sext_o),
        .wb_alu_o(s2_wb_alu_o), .wb_lsu_o(s2_wb_lsu_o), .wb_npc_o(s2_wb_npc_o),
        .use_imm_o(use_imm), .use_shamt_imm_o(use_shamt_imm),
        .lhs_pc_o(lhs_pc), .lhs_zero_o(lhs_zero),
        .trap_o(s2_trap_o), .trap_cause_o(s2_trap_cause_o)
    );

    operand_mux u_opnd (
        .pc_i(s2_pc_o), .imm_i(s2_imm_o),
        .rs1_data_i(s1_rs1_data_i), .rs2_data_i(s1_rs2_data_i),
        .use_imm_i(use_imm), .use_shamt_imm_i(use_shamt_imm),
        .lhs_pc_i(lhs_pc), .lhs_zero_i(lhs_zero),
        .shamt_field_i(s1_instr_i[24:20]),
        .alu_lhs_o(s2_alu_lhs_o), .alu_rhs_o(s2_alu_rhs_o), .alu_shamt_o(s2_alu_shamt_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_decode_stage.sv
// Testbench for the decode stage
// Reads test vectors from a file, drives one instruction per test and
// checks immediates, addresses, flags, traps, operands and the PC
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module tb_decode_stage;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int LINE_W       = 8 * 160;

    logic g_clk, g_resetn, s1_valid_i, s2_ready_i, cf_valid_i, cf_ack_i;
    logic [31:0] s1_instr_i;
    logic [1:0] s1_ferr_i;
    logic [`XLEN-1:0] cf_target_i, s1_rs1_data_i, s1_rs2_data_i;
    wire s1_eat_o, s2_valid_o, s2_trap_o;
    wire [`REG_ADDR_W-1:0] s1_rs1_addr_o, s1_rs2_addr_o, s2_rd_o;
    wire [`XLEN-1:0] s2_pc_o, s2_npc_o, s2_imm_o, s2_rs1_data_o, s2_rs2_data_o;
    wire [`XLEN-1:0] s2_alu_lhs_o, s2_alu_rhs_o;
    wire [31:0] s2_instr_o;
    wire [4:0] s2_alu_shamt_o;
    wire [6:0] s2_trap_cause_o;
    wire s2_alu_add_o, s2_alu_sub_o, s2_alu_and_o, s2_alu_or_o, s2_alu_xor_o;
    wire s2_alu_sll_o, s2_alu_srl_o, s2_alu_sra_o, s2_alu_slt_o, s2_alu_sltu_o;
    wire s2_cfu_beq_o, s2_cfu_bne_o, s2_cfu_blt_o, s2_cfu_bge_o, s2_cfu_bltu_o;
    wire s2_cfu_bgeu_o, s2_cfu_jal_o, s2_cfu_jalr_o, s2_cfu_ecall_o, s2_cfu_ebrk_o;
    wire s2_lsu_load_o, s2_lsu_store_o, s2_lsu_byte_o, s2_lsu_half_o;
    wire s2_lsu_word_o, s2_lsu_sext_o, s2_wb_alu_o, s2_wb_lsu_o, s2_wb_npc_o;

    // Flag order matches the mask column of the test file
    wire [28:0] flags = {s2_alu_add_o, s2_alu_sub_o, s2_alu_and_o, s2_alu_or_o,
        s2_alu_xor_o, s2_alu_sll_o, s2_alu_srl_o, s2_alu_sra_o, s2_alu_slt_o,
        s2_alu_sltu_o, s2_cfu_beq_o, s2_cfu_bne_o, s2_cfu_blt_o, s2_cfu_bge_o,
        s2_cfu_bltu_o, s2_cfu_bgeu_o, s2_cfu_jal_o, s2_cfu_jalr_o, s2_cfu_ecall_o,
        s2_cfu_ebrk_o, s2_lsu_load_o, s2_lsu_store_o, s2_lsu_byte_o, s2_lsu_half_o,
        s2_lsu_word_o, s2_lsu_sext_o, s2_wb_alu_o, s2_wb_lsu_o, s2_wb_npc_o};

    string t_name;
    logic [31:0] t_instr;
    logic [1:0] t_ferr;
    logic t_ready, t_cfv, t_cfa, t_trap, loaded;
    logic [`XLEN-1:0] t_target, t_imm, t_pc_next;
    logic [`REG_ADDR_W-1:0] t_rd, t_rs1, t_rs2;
    logic [11:0] t_opnd;                            // Operand source digits
    logic [28:0] t_flags;
    logic [6:0] t_cause;
    int n_tests, n_run, n_checks, n_errors, t_errors;

    decode_stage u_dut (.*);

    initial g_clk = 1'b0;
    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int parse_line(input logic [LINE_W-1:0] text);
        return $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", t_name,
            t_instr, t_ferr, t_ready, t_cfv, t_cfa, t_target, t_imm, t_rd, t_rs1, t_rs2,
            t_opnd, t_flags, t_trap, t_cause, t_pc_next);
    endfunction

    // Compare tasks
    // ----------------------------------------
    task automatic report_mismatch(input string what, input string exp_s, input string act_s);
        n_errors++;
        t_errors++;
        $display("mismatch %s %s: expected %s, actual %s", t_name, what, exp_s, act_s);
    endtask

    task automatic check_word(input string what, input logic [`XLEN-1:0] exp_v, act_v);
        n_checks++;
        if (act_v !== exp_v) report_mismatch(what, $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic check_reg(input string what, input logic [`REG_ADDR_W-1:0] exp_v, act_v);
        n_checks++;
        if (act_v !== exp_v) report_mismatch(what, $sformatf("%0d", exp_v), $sformatf("%0d", act_v));
    endtask

    task automatic check_bit(input string what, input logic exp_v, act_v);
        n_checks++;
        if (act_v !== exp_v) report_mismatch(what, $sformatf("%b", exp_v), $sformatf("%b", act_v));
    endtask

    task automatic check_flags(input logic [28:0] exp_v, act_v);
        n_checks++;
        if (act_v !== exp_v) report_mismatch("flags", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic check_trap(input logic exp_t, input logic [6:0] exp_c,
                              input logic act_t, input logic [6:0] act_c);
        n_checks++;
        if ({act_t, act_c} !== {exp_t, exp_c})
            report_mismatch("trap", $sformatf("%b/%0d", exp_t, exp_c),
                            $sformatf("%b/%0d", act_t, act_c));
    endtask

    task automatic print_result();
        if (t_errors == 0) $display("test %s: ok", t_name);
        else $display("test %s: %0d errors", t_name, t_errors);
    endtask

    // Watchdog allows 20 cycles per test plus reset
    initial begin
        wait (loaded);
        #((n_tests + 1) * 20 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        $display("run timed out before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    // Main sequence
    // ----------------------------------------
    initial begin
        int fd;
        int code;
        logic [LINE_W-1:0] line;
        logic [LINE_W-1:0] lines[$];
        logic [`XLEN-1:0] pc_exp, d1, d2, lhs_exp;
        logic [31:0] rng;
        {g_resetn, s1_valid_i, s2_ready_i, cf_valid_i, cf_ack_i, loaded} = '0;
        {s1_instr_i, s1_ferr_i, cf_target_i, s1_rs1_data_i, s1_rs2_data_i} = '0;
        {n_tests, n_run, n_checks, n_errors, t_errors} = '0;
        fd = $fopen("tb/decode_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/decode_tests.txt");
            n_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) > 0) begin
                    code = parse_line(line);
                    if (code == 16) lines.push_back(line);
                    else if (code > 0 && t_name != "#") begin
                        $display("malformed line in test file: %0s", line);
                        n_errors++;
                    end
                end
            end
            $fclose(fd);
            if (lines.size() == 0) begin
                $display("no tests found in the test file");
                n_errors++;
            end
        end
        n_tests = lines.size();
        loaded  = 1'b1;

        repeat (RESET_CYCLES) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        t_name = "reset";
        check_word("pc", `PC_RESET_ADDR, s2_pc_o);
        check_word("npc", `PC_RESET_ADDR + 32'd4, s2_npc_o);
        check_bit("eat", 1'b0, s1_eat_o);
        check_bit("valid", 1'b0, s2_valid_o);
        print_result();

        pc_exp = `PC_RESET_ADDR;
        rng    = 32'h077aa518;
        for (int k = 0; k < lines.size(); k++) begin
            code     = parse_line(lines[k]);
            t_errors = 0;
            rng      = lcg_next(rng);
            d1       = rng;
            rng      = lcg_next(rng);
            d2       = rng;
            @(posedge g_clk);
            s1_valid_i    <= 1'b1;
            s1_instr_i    <= t_instr;
            s1_ferr_i     <= t_ferr;
            s2_ready_i    <= t_ready;
            cf_valid_i    <= t_cfv;
            cf_ack_i      <= t_cfa;
            cf_target_i   <= t_target;
            s1_rs1_data_i <= d1;
            s1_rs2_data_i <= d2;
            @(negedge g_clk);                       // Decode outputs settled
            check_word("imm", t_imm, s2_imm_o);
            check_reg("rd", t_rd, s2_rd_o);
            check_reg("rs1_addr", t_rs1, s1_rs1_addr_o);
            check_reg("rs2_addr", t_rs2, s1_rs2_addr_o);
            check_flags(t_flags, flags);
            check_trap(t_trap, t_cause, s2_trap_o, s2_trap_cause_o);
            check_bit("eat", t_ready, s1_eat_o);
            check_bit("valid", 1'b1, s2_valid_o);
            check_word("instr", t_instr, s2_instr_o);
            check_word("rs1_data", d1, s2_rs1_data_o);
            check_word("rs2_data", d2, s2_rs2_data_o);
            check_word("pc", pc_exp, s2_pc_o);
            check_word("npc", pc_exp + 32'd4, s2_npc_o);
            lhs_exp = (t_opnd[11:8] == 4'd1) ? pc_exp : (t_opnd[11:8] == 4'd2) ? '0 : d1;
            check_word("alu_lhs", lhs_exp, s2_alu_lhs_o);
            check_word("alu_rhs", t_opnd[7:4] != 4'd0 ? t_imm : d2, s2_alu_rhs_o);
            check_word("alu_shamt", {27'd0, t_opnd[3:0] != 4'd0 ? t_instr[24:20] : d2[4:0]},
                       {27'd0, s2_alu_shamt_o});
            @(posedge g_clk);                       // PC takes this test's update
            s1_valid_i <= 1'b0;
            cf_valid_i <= 1'b0;
            cf_ack_i   <= 1'b0;
            @(negedge g_clk);
            check_word("pc_next", t_pc_next, s2_pc_o);
            pc_exp = t_pc_next;
            n_run++;
            print_result();
        end

        $display("tests run %0d, checks %0d, errors %0d", n_run, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hw
hw/decode_pkg.sv
hw/pc_tracker.sv
hw/imm_gen.sv
hw/op_decoder.sv
hw/operand_mux.sv
hw/decode_stage.sv
tb/tb_decode_stage.sv

//--- tb/decode_tests.txt
# name instr ferr ready cf_valid cf_ack cf_target | imm rd rs1 rs2 opnd flags trap cause pc_next
# opnd lhs(0 rs1 1 pc 2 zero) rhs(0 rs2 1 imm) shamt(0 rs2 1 field), flags alu..cfu..lsu..wb
addi_pos    00510093 0 1 0 0 00000000 00000005 01 02 05 010 10000004 0 0 10000004
addi_neg    fff20193 0 1 0 0 00000000 ffffffff 03 04 1f 010 10000004 0 0 10000008
sw_pos      00532423 0 1 0 0 00000000 00000008 00 06 05 010 10000094 0 0 1000000c
beq_fwd     00208863 0 1 0 0 00000000 00000010 00 01 02 000 08040000 0 0 10000010
bne_back    fe419ce3 0 1 0 0 00000000 fffffff8 00 03 04 000 08020000 0 0 10000014
blt         0062c263 0 1 0 0 00000000 00000004 00 05 06 000 08010000 0 0 10000018
bge         0062d263 0 1 0 0 00000000 00000004 00 05 06 000 08008000 0 0 1000001c
bgeu        0062f263 0 1 0 0 00000000 00000004 00 05 06 000 08002000 0 0 10000020
lui         12345537 0 1 0 0 00000000 12345000 0a 08 03 210 02000004 0 0 10000024
auipc       fffff597 0 1 0 0 00000000 fffff000 0b 1f 1f 110 10000004 0 0 10000028
jal_fwd     001000ef 0 1 0 0 00000000 00000800 01 00 01 000 00001001 0 0 1000002c
jal_back    ffdff06f 0 1 0 0 00000000 fffffffc 00 1f 1d 000 00001001 0 0 10000030
jalr        00c100e7 0 1 0 0 00000000 0000000c 01 02 0c 000 00000801 0 0 10000034
lb          00068603 0 1 0 0 00000000 00000000 0c 0d 00 010 1000014a 0 0 10000038
lhu         0026d603 0 1 0 0 00000000 00000002 0c 0d 02 010 10000122 0 0 1000003c
lw          ff86a603 0 1 0 0 00000000 fffffff8 0c 0d 18 010 1000011a 0 0 10000040
sb          00e780a3 0 1 0 0 00000000 00000001 00 0f 0e 010 100000c4 0 0 10000044
add         003100b3 0 1 0 0 00000000 00000000 01 02 03 000 10000004 0 0 10000048
sub         403100b3 0 1 0 0 00000000 00000000 01 02 03 000 08000004 0 0 1000004c
sra         403150b3 0 1 0 0 00000000 00000000 01 02 03 000 00200004 0 0 10000050
sltu        003130b3 0 1 0 0 00000000 00000000 01 02 03 000 00080004 0 0 10000054
xor         003140b3 0 1 0 0 00000000 00000000 01 02 03 000 01000004 0 0 10000058
slli        00711093 0 1 0 0 00000000 00000007 01 02 07 011 00800004 0 0 1000005c
srai        41f15093 0 1 0 0 00000000 0000041f 01 02 1f 011 00200004 0 0 10000060
andi        0ff17093 0 1 0 0 00000000 000000ff 01 02 1f 010 04000004 0 0 10000064
ecall       00000073 0 1 0 0 00000000 00000000 00 00 00 000 00000400 0 0 10000068
ebreak      00100073 0 1 0 0 00000000 00000000 00 00 01 000 00000200 0 0 1000006c
bad_opcode  ffffffff 0 1 0 0 00000000 00000000 1f 1f 1f 000 00000000 1 2 10000070
bad_funct7  023100b3 0 1 0 0 00000000 00000000 01 02 03 000 00000000 1 2 10000074
ferr_load   ff86a603 1 1 0 0 00000000 fffffff8 0c 0d 18 010 10000000 1 1 10000078
ferr_prio   ffffffff 2 1 0 0 00000000 00000000 1f 1f 1f 000 00000000 1 1 1000007c
ferr_jal    001000ef 2 1 0 0 00000000 00000800 01 00 01 000 00001000 1 1 10000080
stall       00510093 0 0 0 0 00000000 00000005 01 02 05 010 10000004 0 0 10000080
redir_eat   00510093 0 1 1 1 20000100 00000005 01 02 05 010 10000004 0 0 20000100
cf_no_ack   00510093 0 1 1 0 30000000 00000005 01 02 05 010 10000004 0 0 20000104
redir_stall 00510093 0 0 1 1 10000800 00000005 01 02 05 010 10000004 0 0 10000800
auipc_new   00000597 0 1 0 0 00000000 00000000 0b 00 00 110 10000004 0 0 10000804
